/* filelist.f */
+incdir+src
src/lpif_pkg.sv
src/lpif_ll_if.sv
src/ll_auto_sync.sv
src/lpif_flit_pack.sv
src/lpif_lane_stripe.sv
src/lpif_link_stats.sv
src/lpif_txrx_top.sv
testbench/tb_lpif_txrx.sv

/* Bender.yml */
package:
  name: lpif_txrx

export_include_dirs:
  - src

sources:
  - src/lpif_pkg.sv
  - src/lpif_ll_if.sv
  - src/ll_auto_sync.sv
  - src/lpif_flit_pack.sv
  - src/lpif_lane_stripe.sv
  - src/lpif_link_stats.sv
  - src/lpif_txrx_top.sv
  - target: test
    files:
      - testbench/tb_lpif_txrx.sv

/* testbench/tb_lpif_txrx.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lpif_settings.svh"

module tb_lpif_txrx;
  import lpif_pkg::*;

  localparam int     NUM_CHAN      = `LPIF_NUM_CHAN;
  localparam int     CHAN_PW       = `LPIF_CHAN_W - 3;
  localparam int     PAYLOAD_W     = NUM_CHAN * CHAN_PW;
  localparam delay_t X_DELAY       = 8'd4;
  localparam delay_t XZ_DELAY      = 8'd10;
  localparam delay_t YZ_DELAY      = 8'd4;
  localparam int     PRE_CYCLES    = 20;
  localparam int     SETTLE_CYCLES = 12;
  localparam int     NUM_BEATS     = 500;
  // About 620 cycles of tests and a wide margin
  localparam int     MAX_CYCLES    = 2000;

  logic        clk_wr;
  logic        rst_n;
  logic        tx_online;
  logic        rx_online;
  chan_word_t  tx_phy0, tx_phy1, tx_phy2, tx_phy3;
  chan_word_t  rx_phy0, rx_phy1, rx_phy2, rx_phy3;
  chan_word_t  tx_word_or;
  state_t      dstrm_state, ustrm_state;
  protid_t     dstrm_protid, ustrm_protid;
  data_t       dstrm_data, ustrm_data;
  bstart_t     dstrm_bstart, ustrm_bstart;
  bvalid_t     dstrm_bvalid, ustrm_bvalid;
  logic        dstrm_valid, ustrm_valid;
  dbg_status_t tx_dbg, rx_dbg;
  delay_t      delay_x_value, delay_xz_value, delay_yz_value;

  integer      seed;
  logic        pre_online, link_down, corrupt;
  logic        tx_track, tx_started, rx_cmp;
  flit_t       sent_q [$];
  int          wait_cnt, word_idx, cycle_cnt;
  int          exp_stb_cnt, exp_tx_cnt, rx_valid_cnt;
  marker_t     prev_mrk;

  lpif_txrx_top dut_i (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_online                  (tx_online),
    .rx_online                  (rx_online),
    .tx_phy0                    (tx_phy0),
    .rx_phy0                    (rx_phy0),
    .tx_phy1                    (tx_phy1),
    .rx_phy1                    (rx_phy1),
    .tx_phy2                    (tx_phy2),
    .rx_phy2                    (rx_phy2),
    .tx_phy3                    (tx_phy3),
    .rx_phy3                    (rx_phy3),
    .dstrm_state                (dstrm_state),
    .dstrm_protid               (dstrm_protid),
    .dstrm_data                 (dstrm_data),
    .dstrm_bstart               (dstrm_bstart),
    .dstrm_bvalid               (dstrm_bvalid),
    .dstrm_valid                (dstrm_valid),
    .ustrm_state                (ustrm_state),
    .ustrm_protid               (ustrm_protid),
    .ustrm_data                 (ustrm_data),
    .ustrm_bstart               (ustrm_bstart),
    .ustrm_bvalid               (ustrm_bvalid),
    .ustrm_valid                (ustrm_valid),
    .tx_downstream_debug_status (tx_dbg),
    .rx_upstream_debug_status   (rx_dbg),
    .delay_x_value              (delay_x_value),
    .delay_xz_value             (delay_xz_value),
    .delay_yz_value             (delay_yz_value)
  );

  ////////////////////////////////////////
  // Loopback PHY model
  ////////////////////////////////////////

  // Corruption flips the low marker bit of channel 2
  assign rx_phy0    = tx_phy0;
  assign rx_phy1    = tx_phy1;
  assign rx_phy2    = corrupt ? (tx_phy2 ^ chan_word_t'(24'h2)) : tx_phy2;
  assign rx_phy3    = tx_phy3;
  assign tx_word_or = tx_phy0 | tx_phy1 | tx_phy2 | tx_phy3;

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  always @(posedge clk_wr) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Stopped at the first error");
  endtask

  ////////////////////////////////////////
  // Idle and offline checks
  ////////////////////////////////////////

  idle_tx_words: assert property (@(posedge clk_wr) (pre_online || link_down) |->
                                  tx_word_or == '0)
    else begin
      $display("ERR tx_phy exp 0x000000 got 0x%h", $sampled(tx_word_or));
      abort_run();
    end

  idle_ustrm_valid: assert property (@(posedge clk_wr) (pre_online || link_down) |->
                                     !ustrm_valid)
    else begin
      $display("ERR ustrm_valid exp 0x0 got 0x%h", $sampled(ustrm_valid));
      abort_run();
    end

  idle_tx_status: assert property (@(posedge clk_wr) pre_online |-> tx_dbg == '0)
    else begin
      $display("ERR tx_downstream_debug_status exp 0x0 got 0x%h", $sampled(tx_dbg));
      abort_run();
    end

  idle_rx_status: assert property (@(posedge clk_wr) pre_online |-> rx_dbg == '0)
    else begin
      $display("ERR rx_upstream_debug_status exp 0x0 got 0x%h", $sampled(rx_dbg));
      abort_run();
    end

  ////////////////////////////////////////
  // Stimulus and per-cycle checks
  ////////////////////////////////////////

  // Keeps the last four beats with the oldest first
  task automatic drive_beat();
    state_t  st;
    protid_t pid;
    data_t   d;
    bstart_t bs;
    bvalid_t bv;
    logic    v;
    st  = state_t'($random(seed));
    pid = protid_t'($random(seed));
    d   = {$random(seed), $random(seed)};
    bs  = bstart_t'($random(seed));
    bv  = bvalid_t'($random(seed));
    v   = ($random(seed) & 3) != 0;
    dstrm_state  = st;
    dstrm_protid = pid;
    dstrm_data   = d;
    dstrm_bstart = bs;
    dstrm_bvalid = bv;
    dstrm_valid  = v;
    sent_q.push_back({st, pid, d, bs, bv, v});
    if (sent_q.size() > 4) begin
      sent_q.pop_front();
    end
  endtask

  // Word on the wire now carries the beat driven two cycles ago
  task automatic check_tx_words();
    chan_word_t           words [NUM_CHAN];
    logic [PAYLOAD_W-1:0] exp_pl;
    logic                 exp_stb;
    words[0] = tx_phy0;
    words[1] = tx_phy1;
    words[2] = tx_phy2;
    words[3] = tx_phy3;
    if (tx_track && !tx_started) begin
      wait_cnt++;
      if (tx_word_or != '0) begin
        tx_started = 1'b1;
        word_idx   = 0;
        assert (wait_cnt >= XZ_DELAY && wait_cnt <= XZ_DELAY + 2) else begin
          $display("First tx word came %0d cycles after tx_online rose", wait_cnt);
          abort_run();
        end
      end
    end
    if (tx_track && tx_started) begin
      exp_pl  = PAYLOAD_W'(sent_q[2]);
      exp_stb = (word_idx % `LPIF_STB_INTERVAL) == 0;
      for (int c = 0; c < NUM_CHAN; c++) begin
        assert (words[c][`LPIF_CHAN_W-1:3] == exp_pl[c*CHAN_PW +: CHAN_PW]) else begin
          $display("ERR tx_phy%0d payload exp 0x%h got 0x%h", c,
                   exp_pl[c*CHAN_PW +: CHAN_PW], words[c][`LPIF_CHAN_W-1:3]);
          abort_run();
        end
        if (c > 0) begin
          assert (words[c][2:0] == words[0][2:0]) else begin
            $display("ERR tx_phy%0d strobe/marker exp 0x%h got 0x%h", c,
                     words[0][2:0], words[c][2:0]);
            abort_run();
          end
        end
      end
      assert (words[0][0] == exp_stb) else begin
        $display("ERR tx_phy0 strobe exp 0x%h got 0x%h", exp_stb, words[0][0]);
        abort_run();
      end
      if (word_idx > 0) begin
        assert (words[0][2:1] == marker_t'(prev_mrk + 2'd1)) else begin
          $display("ERR tx_phy0 marker exp 0x%h got 0x%h",
                   marker_t'(prev_mrk + 2'd1), words[0][2:1]);
          abort_run();
        end
      end
      prev_mrk = words[0][2:1];
      if (exp_stb) begin
        exp_stb_cnt++;
      end
      if (sent_q[2][0]) begin
        exp_tx_cnt++;
      end
      word_idx++;
    end
  endtask

  // Upstream beat equals the beat driven four cycles ago
  task automatic check_ustrm();
    flit_t got;
    got = {ustrm_state, ustrm_protid, ustrm_data, ustrm_bstart, ustrm_bvalid, ustrm_valid};
    if (ustrm_valid) begin
      rx_valid_cnt++;
    end
    if (rx_cmp) begin
      assert (got == sent_q[0]) else begin
        $display("ERR ustrm exp 0x%h got 0x%h", sent_q[0], got);
        abort_run();
      end
    end
  endtask

  task automatic check_counters();
    assert (tx_dbg == {count_t'(exp_stb_cnt), count_t'(exp_tx_cnt)}) else begin
      $display("ERR tx_downstream_debug_status exp 0x%h got 0x%h",
               {count_t'(exp_stb_cnt), count_t'(exp_tx_cnt)}, tx_dbg);
      abort_run();
    end
    assert (rx_dbg[`LPIF_CNT_W-1:0] == count_t'(rx_valid_cnt)) else begin
      $display("ERR rx_upstream_debug_status exp 0x%h got 0x%h",
               count_t'(rx_valid_cnt), rx_dbg[`LPIF_CNT_W-1:0]);
      abort_run();
    end
  endtask

  // Outputs are read 1 ns after the edge, then the next beat goes out
  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
    check_tx_words();
    check_ustrm();
    drive_beat();
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int     tx_last;
    int     uv_last;
    count_t err_base;
    count_t err_now;
    seed           = 15535;
    rst_n          = 1'b0;
    tx_online      = 1'b0;
    rx_online      = 1'b0;
    dstrm_state    = '0;
    dstrm_protid   = '0;
    dstrm_data     = '0;
    dstrm_bstart   = '0;
    dstrm_bvalid   = '0;
    dstrm_valid    = 1'b0;
    delay_x_value  = X_DELAY;
    delay_xz_value = XZ_DELAY;
    delay_yz_value = YZ_DELAY;
    pre_online     = 1'b0;
    link_down      = 1'b0;
    corrupt        = 1'b0;
    tx_track       = 1'b0;
    tx_started     = 1'b0;
    rx_cmp         = 1'b0;
    repeat (2) @(posedge clk_wr);
    #1;
    rst_n      = 1'b1;
    pre_online = 1'b1;
    repeat (PRE_CYCLES) next_cycle();

    // Bring the link up
    pre_online = 1'b0;
    tx_online  = 1'b1;
    rx_online  = 1'b1;
    tx_track   = 1'b1;
    while (!tx_started) begin
      next_cycle();
    end
    repeat (SETTLE_CYCLES) next_cycle();

    // Loopback scoreboard over random beats
    rx_cmp = 1'b1;
    repeat (NUM_BEATS) next_cycle();
    check_counters();

    // One word with a bad channel 2 marker
    err_base = rx_dbg[2*`LPIF_CNT_W-1:`LPIF_CNT_W];
    corrupt  = 1'b1;
    next_cycle();
    corrupt = 1'b0;
    repeat (8) next_cycle();
    err_now = rx_dbg[2*`LPIF_CNT_W-1:`LPIF_CNT_W];
    assert (count_t'(err_now - err_base) inside {16'd1, 16'd2}) else begin
      $display("ERR rx_upstream_debug_status[31:16] rise exp 0x1 or 0x2 got 0x%h",
               count_t'(err_now - err_base));
      abort_run();
    end
    repeat (24) next_cycle();
    assert (rx_dbg[2*`LPIF_CNT_W-1:`LPIF_CNT_W] == err_now) else begin
      $display("ERR rx_upstream_debug_status[31:16] exp 0x%h got 0x%h", err_now,
               rx_dbg[2*`LPIF_CNT_W-1:`LPIF_CNT_W]);
      abort_run();
    end
    check_counters();

    // Take the link down
    tx_online = 1'b0;
    tx_track  = 1'b0;
    rx_cmp    = 1'b0;
    tx_last   = 0;
    uv_last   = 0;
    for (int n = 1; n <= 8; n++) begin
      next_cycle();
      if (tx_word_or != '0) begin
        tx_last = n;
      end
      if (ustrm_valid) begin
        uv_last = n;
      end
    end
    assert (tx_last < 2) else begin
      $display("tx_phy still carried words %0d cycles after tx_online fell", tx_last);
      abort_run();
    end
    assert (uv_last < 4) else begin
      $display("ustrm_valid was still high %0d cycles after tx_online fell", uv_last);
      abort_run();
    end
    link_down = 1'b1;
    repeat (10) next_cycle();

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* src/lpif_txrx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lpif_txrx_top (
  input  logic                  clk_wr,
  input  logic                  rst_n,

  // Link control
  input  logic                  tx_online,
  input  logic                  rx_online,

  // PHY channels
  output lpif_pkg::chan_word_t  tx_phy0,
  input  lpif_pkg::chan_word_t  rx_phy0,
  output lpif_pkg::chan_word_t  tx_phy1,
  input  lpif_pkg::chan_word_t  rx_phy1,
  output lpif_pkg::chan_word_t  tx_phy2,
  input  lpif_pkg::chan_word_t  rx_phy2,
  output lpif_pkg::chan_word_t  tx_phy3,
  input  lpif_pkg::chan_word_t  rx_phy3,

  // Downstream stream
  input  lpif_pkg::state_t      dstrm_state,
  input  lpif_pkg::protid_t     dstrm_protid,
  input  lpif_pkg::data_t       dstrm_data,
  input  lpif_pkg::bstart_t     dstrm_bstart,
  input  lpif_pkg::bvalid_t     dstrm_bvalid,
  input  logic                  dstrm_valid,

  // Upstream stream
  output lpif_pkg::state_t      ustrm_state,
  output lpif_pkg::protid_t     ustrm_protid,
  output lpif_pkg::data_t       ustrm_data,
  output lpif_pkg::bstart_t     ustrm_bstart,
  output lpif_pkg::bvalid_t     ustrm_bvalid,
  output logic                  ustrm_valid,

  // Debug
  output lpif_pkg::dbg_status_t tx_downstream_debug_status,
  output lpif_pkg::dbg_status_t rx_upstream_debug_status,

  // Online delay settings
  input  lpif_pkg::delay_t      delay_x_value,
  input  lpif_pkg::delay_t      delay_xz_value,
  input  lpif_pkg::delay_t      delay_yz_value
);
  import lpif_pkg::*;

  logic    tx_online_delay;
  logic    rx_online_delay;
  logic    tx_auto_stb_userbit;
  marker_t tx_auto_mrk_userbit;

  lpif_ll_if ll_if ();

  ////////////////////////////////////////
  // Auto sync
  ////////////////////////////////////////

  ll_auto_sync u_auto_sync (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_xz_value      (delay_xz_value),
    .delay_yz_value      (delay_yz_value),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit)
  );

  ////////////////////////////////////////
  // Stream side
  ////////////////////////////////////////

  lpif_flit_pack u_flit_pack (
    .clk_wr       (clk_wr),
    .rst_n        (rst_n),
    .dstrm_state  (dstrm_state),
    .dstrm_protid (dstrm_protid),
    .dstrm_data   (dstrm_data),
    .dstrm_bstart (dstrm_bstart),
    .dstrm_bvalid (dstrm_bvalid),
    .dstrm_valid  (dstrm_valid),
    .ustrm_state  (ustrm_state),
    .ustrm_protid (ustrm_protid),
    .ustrm_data   (ustrm_data),
    .ustrm_bstart (ustrm_bstart),
    .ustrm_bvalid (ustrm_bvalid),
    .ustrm_valid  (ustrm_valid),
    .ll           (ll_if.pack)
  );

  ////////////////////////////////////////
  // PHY side
  ////////////////////////////////////////

  lpif_lane_stripe u_lane_stripe (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_userbit  (tx_auto_stb_userbit),
    .tx_mrk_userbit  (tx_auto_mrk_userbit),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .tx_phy2         (tx_phy2),
    .tx_phy3         (tx_phy3),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1),
    .rx_phy2         (rx_phy2),
    .rx_phy3         (rx_phy3),
    .ll              (ll_if.phy)
  );

  lpif_link_stats u_link_stats (
    .clk_wr                     (clk_wr),
    .rst_n                      (rst_n),
    .tx_stb_userbit             (tx_auto_stb_userbit),
    .ll                         (ll_if.mon),
    .tx_downstream_debug_status (tx_downstream_debug_status),
    .rx_upstream_debug_status   (rx_upstream_debug_status)
  );

endmodule

`default_nettype wire

/* src/lpif_link_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module lpif_link_stats (
  input  logic                  clk_wr,
  input  logic                  rst_n,
  input  logic                  tx_stb_userbit,
  lpif_ll_if.mon                ll,
  output lpif_pkg::dbg_status_t tx_downstream_debug_status,
  output lpif_pkg::dbg_status_t rx_upstream_debug_status
);
  import lpif_pkg::*;

  count_t tx_flit_cnt_q;
  count_t tx_stb_cnt_q;
  count_t rx_flit_cnt_q;
  count_t mrk_err_cnt_q;

  ////////////////////////////////////////
  // Event counters
  ////////////////////////////////////////

  // All counters wrap
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_flit_cnt_q <= '0;
      tx_stb_cnt_q  <= '0;
      rx_flit_cnt_q <= '0;
      mrk_err_cnt_q <= '0;
    end else begin
      if (ll.tx_pop && ll.tx_flit[0]) begin
        tx_flit_cnt_q <= tx_flit_cnt_q + 1'b1;
      end
      // Strobes that actually went out on the wire
      if (ll.tx_pop && tx_stb_userbit) begin
        tx_stb_cnt_q <= tx_stb_cnt_q + 1'b1;
      end
      if (ll.rx_push && ll.rx_flit[0]) begin
        rx_flit_cnt_q <= rx_flit_cnt_q + 1'b1;
      end
      if (ll.rx_mrk_err) begin
        mrk_err_cnt_q <= mrk_err_cnt_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Status words
  ////////////////////////////////////////

  assign tx_downstream_debug_status = {tx_stb_cnt_q, tx_flit_cnt_q};
  assign rx_upstream_debug_status   = {mrk_err_cnt_q, rx_flit_cnt_q};

endmodule

`default_nettype wire

/* src/lpif_lane_stripe.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lpif_settings.svh"

module lpif_lane_stripe (
  input  logic                 clk_wr,
  input  logic                 rst_n,
  input  logic                 tx_online_delay,
  input  logic                 rx_online_delay,
  input  logic                 tx_stb_userbit,
  input  lpif_pkg::marker_t    tx_mrk_userbit,

  output lpif_pkg::chan_word_t tx_phy0,
  output lpif_pkg::chan_word_t tx_phy1,
  output lpif_pkg::chan_word_t tx_phy2,
  output lpif_pkg::chan_word_t tx_phy3,
  input  lpif_pkg::chan_word_t rx_phy0,
  input  lpif_pkg::chan_word_t rx_phy1,
  input  lpif_pkg::chan_word_t rx_phy2,
  input  lpif_pkg::chan_word_t rx_phy3,

  lpif_ll_if.phy               ll
);
  import lpif_pkg::*;

  localparam int NUM_CHAN  = `LPIF_NUM_CHAN;
  localparam int CHAN_PW   = `LPIF_CHAN_W - 3;
  localparam int PAYLOAD_W = NUM_CHAN * CHAN_PW;

  logic [PAYLOAD_W-1:0] tx_payload;
  logic [PAYLOAD_W-1:0] rx_payload;
  chan_word_t           tx_word_q [NUM_CHAN];
  chan_word_t           rx_word   [NUM_CHAN];
  flit_t                rx_flit_q;
  logic                 rx_push_q;
  marker_t              mrk_ref_q;
  logic                 mrk_seen_q;
  logic                 mrk_err_q;
  logic                 mrk_mismatch;
  logic                 mrk_seq_bad;

  ////////////////////////////////////////
  // Tx striping
  ////////////////////////////////////////

  // Top payload bits of the last channel stay zero
  assign tx_payload = PAYLOAD_W'(ll.tx_flit);
  assign ll.tx_pop  = tx_online_delay;

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        tx_word_q[c] <= '0;
      end
    end else begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        if (tx_online_delay) begin
          tx_word_q[c] <= {tx_payload[c*CHAN_PW +: CHAN_PW], tx_mrk_userbit, tx_stb_userbit};
        end else begin
          tx_word_q[c] <= '0;
        end
      end
    end
  end

  assign tx_phy0 = tx_word_q[0];
  assign tx_phy1 = tx_word_q[1];
  assign tx_phy2 = tx_word_q[2];
  assign tx_phy3 = tx_word_q[3];

  ////////////////////////////////////////
  // Rx reassembly
  ////////////////////////////////////////

  assign rx_word[0] = rx_phy0;
  assign rx_word[1] = rx_phy1;
  assign rx_word[2] = rx_phy2;
  assign rx_word[3] = rx_phy3;

  always_comb begin
    for (int c = 0; c < NUM_CHAN; c++) begin
      rx_payload[c*CHAN_PW +: CHAN_PW] = rx_word[c][`LPIF_CHAN_W-1:3];
    end
  end

  always_ff @(posedge clk_wr) begin
    rx_flit_q <= rx_online_delay ? rx_payload[FLIT_W-1:0] : '0;
  end

  assign ll.rx_flit = rx_flit_q;
  assign ll.rx_push = rx_push_q;

  ////////////////////////////////////////
  // Marker check
  ////////////////////////////////////////

  // All channels of one word share a marker
  always_comb begin
    mrk_mismatch = 1'b0;
    for (int c = 1; c < NUM_CHAN; c++) begin
      if (rx_word[c][2:1] != rx_word[0][2:1]) begin
        mrk_mismatch = 1'b1;
      end
    end
  end

  assign mrk_seq_bad = (rx_word[0][2:1] != marker_t'(mrk_ref_q + 2'd1));

  // First online word only seeds the reference
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_push_q  <= 1'b0;
      mrk_seen_q <= 1'b0;
      mrk_ref_q  <= '0;
      mrk_err_q  <= 1'b0;
    end else begin
      rx_push_q  <= rx_online_delay;
      mrk_seen_q <= rx_online_delay;
      mrk_err_q  <= rx_online_delay && mrk_seen_q && (mrk_mismatch || mrk_seq_bad);
      if (rx_online_delay) begin
        mrk_ref_q <= rx_word[0][2:1];
      end
    end
  end

  assign ll.rx_mrk_err = mrk_err_q;

endmodule

`default_nettype wire

/* src/lpif_flit_pack.sv */
`timescale 1ns/1ps
`default_nettype none

module lpif_flit_pack (
  input  logic              clk_wr,
  input  logic              rst_n,

  // Downstream beat
  input  lpif_pkg::state_t  dstrm_state,
  input  lpif_pkg::protid_t dstrm_protid,
  input  lpif_pkg::data_t   dstrm_data,
  input  lpif_pkg::bstart_t dstrm_bstart,
  input  lpif_pkg::bvalid_t dstrm_bvalid,
  input  logic              dstrm_valid,

  // Upstream beat
  output lpif_pkg::state_t  ustrm_state,
  output lpif_pkg::protid_t ustrm_protid,
  output lpif_pkg::data_t   ustrm_data,
  output lpif_pkg::bstart_t ustrm_bstart,
  output lpif_pkg::bvalid_t ustrm_bvalid,
  output logic              ustrm_valid,

  lpif_ll_if.pack           ll
);
  import lpif_pkg::*;

  flit_t tx_flit_q;

  ////////////////////////////////////////
  // Downstream packing
  ////////////////////////////////////////

  // Layout from bit 0: valid, bvalid, bstart, data, protid, state
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_flit_q <= '0;
    end else begin
      tx_flit_q <= {dstrm_state, dstrm_protid, dstrm_data,
                    dstrm_bstart, dstrm_bvalid, dstrm_valid};
    end
  end

  assign ll.tx_flit = tx_flit_q;

  ////////////////////////////////////////
  // Upstream unpacking
  ////////////////////////////////////////

  // Valid only on push cycles
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      ustrm_valid <= 1'b0;
    end else begin
      ustrm_valid <= ll.rx_push && ll.rx_flit[0];
    end
  end

  // Fields hold between pushes
  always_ff @(posedge clk_wr) begin
    if (ll.rx_push) begin
      {ustrm_state, ustrm_protid, ustrm_data, ustrm_bstart, ustrm_bvalid} <=
        ll.rx_flit[FLIT_W-1:1];
    end
  end

endmodule

`default_nettype wire

/* src/ll_auto_sync.sv */
`timescale 1ns/1ps
`default_nettype none
`include "lpif_settings.svh"

module ll_auto_sync (
  input  logic              clk_wr,
  input  logic              rst_n,
  input  logic              tx_online,
  input  logic              rx_online,
  input  lpif_pkg::delay_t  delay_x_value,
  input  lpif_pkg::delay_t  delay_xz_value,
  input  lpif_pkg::delay_t  delay_yz_value,
  output logic              tx_online_delay,
  output logic              rx_online_delay,
  output logic              tx_auto_stb_userbit,
  output lpif_pkg::marker_t tx_auto_mrk_userbit
);
  import lpif_pkg::*;

  localparam int STB_CNT_W = $clog2(`LPIF_STB_INTERVAL);

  sync_state_e          tx_state_q;
  delay_t               xz_cnt_q;
  delay_t               x_cnt_q;
  delay_t               yz_cnt_q;
  logic                 x_done;
  logic                 yz_done;
  logic [STB_CNT_W-1:0] stb_cnt_q;
  marker_t              mrk_q;

  ////////////////////////////////////////
  // Tx online delay
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_state_q <= OFFLINE;
      xz_cnt_q   <= '0;
    end else if (!tx_online) begin
      tx_state_q <= OFFLINE;
      xz_cnt_q   <= '0;
    end else begin
      case (tx_state_q)
        OFFLINE: begin
          tx_state_q <= WAIT_XZ;
          xz_cnt_q   <= '0;
        end
        WAIT_XZ: begin
          // Counter tops out one short of the setting
          if (xz_cnt_q + 8'd1 >= delay_xz_value) begin
            tx_state_q <= ONLINE;
          end else begin
            xz_cnt_q <= xz_cnt_q + 8'd1;
          end
        end
        default: tx_state_q <= ONLINE;
      endcase
    end
  end

  assign tx_online_delay = (tx_state_q == ONLINE);

  ////////////////////////////////////////
  // Rx online delay
  ////////////////////////////////////////

  // Both hold timers saturate at their setting
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      x_cnt_q  <= '0;
      yz_cnt_q <= '0;
    end else begin
      if (!rx_online) begin
        x_cnt_q <= '0;
      end else if (!x_done) begin
        x_cnt_q <= x_cnt_q + 8'd1;
      end
      if (!tx_online_delay) begin
        yz_cnt_q <= '0;
      end else if (!yz_done) begin
        yz_cnt_q <= yz_cnt_q + 8'd1;
      end
    end
  end

  assign x_done  = (x_cnt_q >= delay_x_value);
  assign yz_done = tx_online_delay && (yz_cnt_q >= delay_yz_value);

  // Drops together with the tx side so no idle words get checked
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_online_delay <= 1'b0;
    end else begin
      rx_online_delay <= rx_online && tx_online && x_done && yz_done;
    end
  end

  ////////////////////////////////////////
  // Strobe and marker generation
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      stb_cnt_q <= '0;
      mrk_q     <= '0;
    end else if (!tx_online_delay) begin
      stb_cnt_q <= '0;
      mrk_q     <= '0;
    end else begin
      mrk_q <= mrk_q + 2'd1;
      if (stb_cnt_q == STB_CNT_W'(`LPIF_STB_INTERVAL - 1)) begin
        stb_cnt_q <= '0;
      end else begin
        stb_cnt_q <= stb_cnt_q + 1'b1;
      end
    end
  end

  // First word after going online carries a strobe
  assign tx_auto_stb_userbit = tx_online_delay && (stb_cnt_q == '0);
  assign tx_auto_mrk_userbit = mrk_q;

endmodule

`default_nettype wire

/* src/lpif_ll_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface lpif_ll_if;
  import lpif_pkg::*;

  // Tx flit from packer, taken by striper
  flit_t tx_flit;
  logic  tx_pop;

  // Reassembled rx flit and marker status
  flit_t rx_flit;
  logic  rx_push;
  logic  rx_mrk_err;

  modport pack (
    output tx_flit,
    input  rx_flit,
    input  rx_push
  );

  modport phy (
    input  tx_flit,
    output tx_pop,
    output rx_flit,
    output rx_push,
    output rx_mrk_err
  );

  // Statistics only observe
  modport mon (
    input tx_flit,
    input tx_pop,
    input rx_flit,
    input rx_push,
    input rx_mrk_err
  );

endinterface

`default_nettype wire

/* src/lpif_pkg.sv */
`default_nettype none
`include "lpif_settings.svh"

package lpif_pkg;

  ////////////////////////////////////////
  // Stream fields
  ////////////////////////////////////////

  typedef logic [3:0]  state_t;
  typedef logic [1:0]  protid_t;
  typedef logic [63:0] data_t;
  typedef logic [2:0]  bstart_t;
  typedef logic [7:0]  bvalid_t;

  // Packed beat, valid at bit 0
  localparam int FLIT_W = $bits(state_t) + $bits(protid_t) + $bits(data_t) +
                          $bits(bstart_t) + $bits(bvalid_t) + 1;

  typedef logic [FLIT_W-1:0] flit_t;

  ////////////////////////////////////////
  // PHY side and control
  ////////////////////////////////////////

  // Strobe at bit 0, marker at 2..1, payload above
  typedef logic [`LPIF_CHAN_W-1:0] chan_word_t;
  typedef logic [1:0]              marker_t;
  typedef logic [7:0]              delay_t;
  typedef logic [`LPIF_CNT_W-1:0]  count_t;
  typedef logic [2*`LPIF_CNT_W-1:0] dbg_status_t;

  // Tx auto-sync states
  typedef enum logic [1:0] {
    OFFLINE,
    WAIT_XZ,
    ONLINE
  } sync_state_e;

endpackage

`default_nettype wire

/* src/lpif_settings.svh */
`ifndef LPIF_SETTINGS_SVH
`define LPIF_SETTINGS_SVH

////////////////////////////////////////
// PHY channel geometry
////////////////////////////////////////

// Number of die-to-die channels
`define LPIF_NUM_CHAN 4

// Bits per channel word, strobe and marker included
`define LPIF_CHAN_W 24

////////////////////////////////////////
// Auto-sync and debug
////////////////////////////////////////

// Words between two auto strobes
`define LPIF_STB_INTERVAL 16

// Width of each debug counter
`define LPIF_CNT_W 16

`endif
